// ==== test/decode_tests.txt ====
// valid instr illegal aluOp then aluSrc zeroExtend shamtOperand zeroOperands swapOperands
// regWrite regDst hiLoMove hiLoAccum hiLoSubtract, all hex
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 // NOP
1 00000040 0 b 1 0 1 0 0 1 1 0 0 0 // SLL sa 1, not NOP
1 00021900 0 b 1 0 1 0 0 1 1 0 0 0 // SLL
1 00021902 0 c 1 0 1 0 0 1 1 0 0 0 // SRL
1 00221902 0 d 1 0 1 0 1 1 1 0 0 0 // ROTR
1 00421902 1 0 0 0 0 0 0 0 0 0 0 0 // SRL form with rs 2
1 00021903 0 e 0 0 1 0 0 1 1 0 0 0 // SRA
1 00821804 0 5 0 0 0 0 1 1 1 0 0 0 // SLLV
1 00821806 0 f 0 0 0 0 1 1 1 0 0 0 // SRLV
1 00821846 0 d 1 0 0 0 0 1 1 0 0 0 // ROTRV
1 00821886 1 0 0 0 0 0 0 0 0 0 0 0 // SRLV form with sa 2
1 00821807 0 e 0 0 0 0 1 1 1 0 0 0 // SRAV
1 00821820 0 2 0 0 0 0 0 1 1 0 0 0 // ADD
1 00821821 0 2 0 0 0 0 0 1 1 0 0 0 // ADDU
1 00821822 0 6 0 0 0 0 0 1 1 0 0 0 // SUB
1 00821824 0 0 0 0 0 0 0 1 1 0 0 0 // AND
1 00821825 0 1 0 0 0 0 0 1 1 0 0 0 // OR
1 00821826 0 4 0 0 0 0 0 1 1 0 0 0 // XOR
1 00821827 0 3 0 0 0 0 0 1 1 0 0 0 // NOR
1 0082182a 0 7 0 0 0 0 0 1 1 0 0 0 // SLT
1 0082182b 0 7 0 0 0 0 0 1 1 0 0 0 // SLTU
1 0082180a 0 2 0 0 1 1 0 1 1 0 0 0 // MOVZ
1 0082180b 0 2 0 0 1 1 0 1 1 0 0 0 // MOVN
0 00821820 0 0 0 0 0 0 0 0 0 0 0 0 // Bubble
1 00820018 0 8 0 0 0 0 0 0 0 1 0 0 // MULT
1 00820019 0 8 0 0 0 0 0 0 0 1 0 0 // MULTU
1 70820000 0 8 0 0 0 0 0 0 0 0 1 0 // MADD
1 70820004 0 8 0 0 0 0 0 0 0 0 1 1 // MSUB
1 70821802 0 8 0 0 0 0 0 1 1 0 0 0 // MUL
1 7c021c20 0 a 0 0 0 0 0 1 1 0 0 0 // SEB
1 7c021e20 0 9 0 0 0 0 0 1 1 0 0 0 // SEH
1 7c821c20 1 0 0 0 0 0 0 0 0 0 0 0 // SEB form with rs 4
1 20821234 0 2 1 0 0 0 0 1 0 0 0 0 // ADDI
1 24821234 0 2 1 1 0 0 0 1 0 0 0 0 // ADDIU
1 28821234 0 7 1 0 0 0 0 1 0 0 0 0 // SLTI
1 2c821234 0 7 1 1 0 0 0 1 0 0 0 0 // SLTIU
1 30821234 0 0 1 0 0 0 0 1 0 0 0 0 // ANDI
1 34821234 0 1 1 0 0 0 0 1 0 0 0 0 // ORI
1 38821234 0 4 1 0 0 0 0 1 0 0 0 0 // XORI
1 8c821234 1 0 0 0 0 0 0 0 0 0 0 0 // LW, not decoded
1 00800008 1 0 0 0 0 0 0 0 0 0 0 0 // JR, not decoded
1 ffffffff 1 0 0 0 0 0 0 0 0 0 0 0 // All ones
0 ffffffff 0 0 0 0 0 0 0 0 0 0 0 0 // Bubble

// ==== sources.f ====
design/decodePkg.sv
design/ctrlIf.sv
design/instrClassify.sv
design/aluCtrlGen.sv
design/wbCtrlGen.sv
design/decodeStage.sv
test/decodeStage_props.sv
test/decodeStage_tb.sv

// ==== Bender.yml ====
package:
  name: decodeStage

sources:
  - design/decodePkg.sv
  - design/ctrlIf.sv
  - design/instrClassify.sv
  - design/aluCtrlGen.sv
  - design/wbCtrlGen.sv
  - design/decodeStage.sv
  - target: test
    files:
      - test/decodeStage_props.sv
      - test/decodeStage_tb.sv

// ==== test/decodeStage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeStage_tb
        import decodePkg::*;
();

        localparam int fieldsPerLine = 14;      // valid, instr, illegal, aluOp, ten bits
        localparam int maxLines      = 64;
        localparam int resetTimeout  = 20;

        logic   clk;
        logic   arstN;
        instr_t instr;
        logic   instrValid;
        logic   ctrlValid;
        logic   illegal;
        aluOp_t aluOp;
        logic   aluSrc;
        logic   zeroExtend;
        logic   shamtOperand;
        logic   zeroOperands;
        logic   swapOperands;
        logic   regWrite;
        logic   regDst;
        logic   hiLoMove;
        logic   hiLoAccum;
        logic   hiLoSubtract;

        logic [31:0] testMem [0:fieldsPerLine*maxLines-1];
        int          numLines;

        decodeStage u_decodeStage (
                .clk          (clk),
                .arstN        (arstN),
                .instr        (instr),
                .instrValid   (instrValid),
                .ctrlValid    (ctrlValid),
                .illegal      (illegal),
                .aluOp        (aluOp),
                .aluSrc       (aluSrc),
                .zeroExtend   (zeroExtend),
                .shamtOperand (shamtOperand),
                .zeroOperands (zeroOperands),
                .swapOperands (swapOperands),
                .regWrite     (regWrite),
                .regDst       (regDst),
                .hiLoMove     (hiLoMove),
                .hiLoAccum    (hiLoAccum),
                .hiLoSubtract (hiLoSubtract)
        );

        //////////////////////////////
        // Clock and reset

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        initial begin
                arstN = 1'b0;
                repeat (4) @(posedge clk);
                @(negedge clk);
                arstN <= 1'b1;                          // Seen by the checker one edge later
        end

        //////////////////////////////
        // Checking

        task automatic checkBit(input int lineNo, input string name, input logic expected,
                                input logic actual);
                assert (actual === expected) else begin
                        $display("[ERROR] line %0d %s expected 0x%0h actual 0x%0h",
                                 lineNo, name, expected, actual);
                        $display("Simulation failed");
                        $fatal(1, "Mismatch on %s", name);
                end
        endtask

        task automatic checkOutputs(input int lineNo, input logic expValid,
                                    input logic expIllegal, input logic [3:0] expAlu,
                                    input logic [9:0] expBits);
                aluOp_t expOp;
                expOp = aluOp_t'(expAlu);
                checkBit(lineNo, "ctrlValid", expValid, ctrlValid);
                checkBit(lineNo, "illegal", expIllegal, illegal);
                assert (aluOp === expOp) else begin
                        $display("[ERROR] line %0d aluOp expected 0x%0h (%s) actual 0x%0h (%s)",
                                 lineNo, expOp, expOp.name(), aluOp, aluOp.name());
                        $display("Simulation failed");
                        $fatal(1, "Mismatch on aluOp");
                end
                checkBit(lineNo, "aluSrc", expBits[9], aluSrc);
                checkBit(lineNo, "zeroExtend", expBits[8], zeroExtend);
                checkBit(lineNo, "shamtOperand", expBits[7], shamtOperand);
                checkBit(lineNo, "zeroOperands", expBits[6], zeroOperands);
                checkBit(lineNo, "swapOperands", expBits[5], swapOperands);
                checkBit(lineNo, "regWrite", expBits[4], regWrite);
                checkBit(lineNo, "regDst", expBits[3], regDst);
                checkBit(lineNo, "hiLoMove", expBits[2], hiLoMove);
                checkBit(lineNo, "hiLoAccum", expBits[1], hiLoAccum);
                checkBit(lineNo, "hiLoSubtract", expBits[0], hiLoSubtract);
        endtask

        // Ten control columns, aluSrc first
        function automatic logic [9:0] controlBits(input int base);
                logic [9:0] bits;
                for (int k = 0; k < 10; k++)
                        bits[9 - k] = testMem[base + 4 + k][0];
                return bits;
        endfunction

        //////////////////////////////
        // Bound property failures

        always @(u_decodeStage.u_props.failCount) begin
                assert (u_decodeStage.u_props.failCount == 0) else begin
                        $display("Bound property failure count %0d",
                                 u_decodeStage.u_props.failCount);
                        $display("Simulation failed");
                        $fatal(1, "Property failure");
                end
        end

        //////////////////////////////
        // Stimulus

        initial begin
                int cycles;
                int base;
                instr      = '0;
                instrValid = 1'b0;
                $readmemh("test/decode_tests.txt", testMem);
                numLines = 0;
                while (numLines < maxLines && !$isunknown(testMem[numLines*fieldsPerLine]))
                        numLines++;
                if (numLines == 0) begin
                        $display("No test lines found in test/decode_tests.txt");
                        $display("Simulation failed");
                        $fatal(1, "Empty stimulus file");
                end

                cycles = 0;
                while (!arstN) begin                    // Outputs stay zero in reset
                        @(negedge clk);
                        checkOutputs(0, 1'b0, 1'b0, 4'h0, 10'h0);
                        cycles++;
                        if (cycles > resetTimeout) begin
                                $display("Reset was not released within %0d cycles",
                                         resetTimeout);
                                $display("Simulation failed");
                                $fatal(1, "Reset timeout");
                        end
                end
                @(negedge clk);
                checkOutputs(0, 1'b0, 1'b0, 4'h0, 10'h0);     // Idle after reset

                // Lines go in back to back, each checked one cycle later
                for (int i = 0; i < numLines; i++) begin
                        base       = i * fieldsPerLine;
                        instrValid = testMem[base][0];
                        instr      = testMem[base + 1];
                        @(negedge clk);
                        checkOutputs(i + 1, testMem[base][0], testMem[base + 2][0],
                                     testMem[base + 3][3:0], controlBits(base));
                end

                @(negedge clk);                         // Last edge seen by the properties
                $display("Simulation passed");
                $finish;
        end

endmodule

`default_nettype wire

// ==== test/decodeStage_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeStage_props
        import decodePkg::*;
(
        input logic   clk,
        input logic   arstN,
        input logic   ctrlValid,
        input logic   illegal,
        input aluOp_t aluOp,
        input logic   aluSrc,
        input logic   zeroExtend,
        input logic   shamtOperand,
        input logic   zeroOperands,
        input logic   swapOperands,
        input logic   regWrite,
        input logic   regDst,
        input logic   hiLoMove,
        input logic   hiLoAccum,
        input logic   hiLoSubtract
);

        int unsigned failCount = 0;             // Failed assertion tally
        logic        ctrlsIdle;

        assign ctrlsIdle = (aluOp == aluAnd) && !aluSrc && !zeroExtend && !shamtOperand &&
                           !zeroOperands && !swapOperands && !regWrite && !regDst &&
                           !hiLoMove && !hiLoAccum && !hiLoSubtract;

        //////////////////////////////
        // Control output rules

        bubbleIdle: assert property (@(posedge clk) disable iff (!arstN)
                        !ctrlValid |-> ctrlsIdle && !illegal)
                else begin
                        $error("Controls active without a valid instruction");
                        failCount++;
                end

        illegalIdle: assert property (@(posedge clk) disable iff (!arstN)
                        illegal |-> ctrlsIdle)
                else begin
                        $error("Controls active on an illegal instruction");
                        failCount++;
                end

        subNeedsAccum: assert property (@(posedge clk) disable iff (!arstN)
                        hiLoSubtract |-> hiLoAccum)
                else begin
                        $error("HI/LO subtract without accumulate");
                        failCount++;
                end

        writeOrMove: assert property (@(posedge clk) disable iff (!arstN)
                        !(regWrite && hiLoMove))
                else begin
                        $error("Register write and HI/LO move both set");
                        failCount++;
                end

endmodule

bind decodeStage decodeStage_props u_props (.*);

`default_nettype wire

// ==== design/decodeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeStage
        import decodePkg::*;
(
        input  logic   clk,
        input  logic   arstN,
        input  instr_t instr,
        input  logic   instrValid,
        output logic   ctrlValid,
        output logic   illegal,
        output aluOp_t aluOp,
        output logic   aluSrc,
        output logic   zeroExtend,
        output logic   shamtOperand,
        output logic   zeroOperands,
        output logic   swapOperands,
        output logic   regWrite,
        output logic   regDst,
        output logic   hiLoMove,
        output logic   hiLoAccum,
        output logic   hiLoSubtract
);

        instrKind_t instrKind;
        logic       decIllegal;

        ctrlIf ctrl ();

        //////////////////////////////
        // Decoders

        instrClassify u_instrClassify (
                .instr     (instr),
                .instrKind (instrKind),
                .illegal   (decIllegal)
        );

        aluCtrlGen u_aluCtrlGen (
                .instrKind (instrKind),
                .ctrl      (ctrl)
        );

        wbCtrlGen u_wbCtrlGen (
                .instrKind (instrKind),
                .ctrl      (ctrl)
        );

        //////////////////////////////
        // Decode to execute register

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        ctrlValid    <= 1'b0;
                        illegal      <= 1'b0;
                        aluOp        <= aluAnd;
                        aluSrc       <= 1'b0;
                        zeroExtend   <= 1'b0;
                        shamtOperand <= 1'b0;
                        zeroOperands <= 1'b0;
                        swapOperands <= 1'b0;
                        regWrite     <= 1'b0;
                        regDst       <= 1'b0;
                        hiLoMove     <= 1'b0;
                        hiLoAccum    <= 1'b0;
                        hiLoSubtract <= 1'b0;
                end else begin
                        ctrlValid    <= instrValid;
                        illegal      <= instrValid && decIllegal;       // Bubble when not valid
                        aluOp        <= instrValid ? ctrl.aluOp : aluAnd;
                        aluSrc       <= instrValid && ctrl.aluSrc;
                        zeroExtend   <= instrValid && ctrl.zeroExtend;
                        shamtOperand <= instrValid && ctrl.shamtOperand;
                        zeroOperands <= instrValid && ctrl.zeroOperands;
                        swapOperands <= instrValid && ctrl.swapOperands;
                        regWrite     <= instrValid && ctrl.regWrite;
                        regDst       <= instrValid && ctrl.regDst;
                        hiLoMove     <= instrValid && ctrl.hiLoMove;
                        hiLoAccum    <= instrValid && ctrl.hiLoAccum;
                        hiLoSubtract <= instrValid && ctrl.hiLoSubtract;
                end
        end

endmodule

`default_nettype wire

// ==== design/wbCtrlGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module wbCtrlGen
        import decodePkg::*;
(
        input instrKind_t   instrKind,
        ctrlIf.wbSide       ctrl
);

        logic noWrite;
        logic immForm;

        //////////////////////////////
        // Register writeback

        // HI/LO only ops and non-instructions
        assign noWrite = instrKind inside {
                kNop, kMult, kMultu, kMadd, kMsub, kIllegal
        };

        // I-type forms write rt instead of rd
        assign immForm = instrKind inside {
                kAddi, kAddiu, kAndi, kOri, kXori, kSlti, kSltiu
        };

        assign ctrl.regWrite = !noWrite;
        assign ctrl.regDst   = !noWrite && !immForm;

        //////////////////////////////
        // HI/LO accumulator

        always_comb begin
                ctrl.hiLoMove     = 1'b0;
                ctrl.hiLoAccum    = 1'b0;
                ctrl.hiLoSubtract = 1'b0;
                case (instrKind)
                        kMult, kMultu: begin
                                ctrl.hiLoMove = 1'b1;           // Product straight in
                        end
                        kMadd: begin
                                ctrl.hiLoAccum = 1'b1;
                        end
                        kMsub: begin
                                ctrl.hiLoAccum    = 1'b1;
                                ctrl.hiLoSubtract = 1'b1;       // Accumulate negated
                        end
                        default: begin
                                ctrl.hiLoMove = 1'b0;
                        end
                endcase
        end

endmodule

`default_nettype wire

// ==== design/aluCtrlGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluCtrlGen
        import decodePkg::*;
(
        input instrKind_t   instrKind,
        ctrlIf.aluSide      ctrl
);

        //////////////////////////////
        // ALU operation

        always_comb begin
                case (instrKind)
                        kAdd, kAddu, kAddi, kAddiu,
                        kMovn, kMovz:                   ctrl.aluOp = aluAdd;    // Moves pass through add
                        kSub:                           ctrl.aluOp = aluSub;
                        kMul, kMult, kMultu,
                        kMadd, kMsub:                   ctrl.aluOp = aluMul;
                        kAnd, kAndi:                    ctrl.aluOp = aluAnd;
                        kOr, kOri:                      ctrl.aluOp = aluOr;
                        kNor:                           ctrl.aluOp = aluNor;
                        kXor, kXori:                    ctrl.aluOp = aluXor;
                        kSll:                           ctrl.aluOp = aluSll;
                        kSrl:                           ctrl.aluOp = aluSrl;
                        kSllv:                          ctrl.aluOp = aluSllv;
                        kSrlv:                          ctrl.aluOp = aluSrlv;
                        kSra, kSrav:                    ctrl.aluOp = aluSra;
                        kRotr, kRotrv:                  ctrl.aluOp = aluRotr;
                        kSlt, kSltu, kSlti, kSltiu:     ctrl.aluOp = aluSlt;
                        kSeb:                           ctrl.aluOp = aluSeb;
                        kSeh:                           ctrl.aluOp = aluSeh;
                        default:                        ctrl.aluOp = aluAnd;    // NOP and illegal
                endcase
        end

        //////////////////////////////
        // Operand select

        // Immediate on the second operand. ROTRV is in the list as well
        assign ctrl.aluSrc = instrKind inside {
                kAddi, kAddiu, kAndi, kOri, kXori, kSlti, kSltiu,
                kSll, kSrl, kRotr, kRotrv
        };

        assign ctrl.zeroExtend = instrKind inside {kAddiu, kSltiu};

        assign ctrl.shamtOperand = instrKind inside {
                kSll, kSrl, kRotr, kSra, kMovn, kMovz
        };

        assign ctrl.zeroOperands = instrKind inside {kMovn, kMovz};     // Condition on rt

        assign ctrl.swapOperands = instrKind inside {kSllv, kSrlv, kSrav, kRotr};

endmodule

`default_nettype wire

// ==== design/instrClassify.sv ====
`timescale 1ns/10ps
`default_nettype none

module instrClassify
        import decodePkg::*;
(
        input  instr_t     instr,
        output instrKind_t instrKind,
        output logic       illegal
);

        opcode_t opcode;
        funct_t  funct;
        regIdx_t rs;
        regIdx_t sa;

        assign opcode = instr[31:26];
        assign rs     = instr[25:21];
        assign sa     = instr[10:6];
        assign funct  = instr[5:0];

        //////////////////////////////
        // Pattern match

        always_comb begin
                instrKind = kIllegal;
                if (instr == '0) begin
                        instrKind = kNop;                       // Wins over SLL
                end else begin
                        case (opcode)
                                opSpecial: begin
                                        case (funct)
                                                fnAdd:   instrKind = kAdd;
                                                fnAddu:  instrKind = kAddu;
                                                fnSub:   instrKind = kSub;
                                                fnMult:  instrKind = kMult;
                                                fnMultu: instrKind = kMultu;
                                                fnAnd:   instrKind = kAnd;
                                                fnOr:    instrKind = kOr;
                                                fnNor:   instrKind = kNor;
                                                fnXor:   instrKind = kXor;
                                                fnSll:   instrKind = kSll;
                                                fnSrl: begin
                                                        if (rs == '0)
                                                                instrKind = kSrl;
                                                        else if (rs == rotrSel)
                                                                instrKind = kRotr;
                                                end
                                                fnSllv:  instrKind = kSllv;
                                                fnSrlv: begin
                                                        if (sa == '0)
                                                                instrKind = kSrlv;
                                                        else if (sa == rotrSel)
                                                                instrKind = kRotrv;
                                                end
                                                fnSlt:   instrKind = kSlt;
                                                fnSltu:  instrKind = kSltu;
                                                fnMovn:  instrKind = kMovn;
                                                fnMovz:  instrKind = kMovz;
                                                fnSra:   instrKind = kSra;
                                                fnSrav:  instrKind = kSrav;
                                                default: instrKind = kIllegal;
                                        endcase
                                end
                                opSpecial2: begin
                                        case (funct)
                                                fnMul:   instrKind = kMul;
                                                fnMadd:  instrKind = kMadd;
                                                fnMsub:  instrKind = kMsub;
                                                default: instrKind = kIllegal;
                                        endcase
                                end
                                opSpecial3: begin
                                        // BSHFL with the sa field picking the width
                                        if (funct == fnBshfl && rs == '0) begin
                                                if (sa == saSeb)
                                                        instrKind = kSeb;
                                                else if (sa == saSeh)
                                                        instrKind = kSeh;
                                        end
                                end
                                opAddi:  instrKind = kAddi;
                                opAddiu: instrKind = kAddiu;
                                opSlti:  instrKind = kSlti;
                                opSltiu: instrKind = kSltiu;
                                opAndi:  instrKind = kAndi;
                                opOri:   instrKind = kOri;
                                opXori:  instrKind = kXori;
                                default: instrKind = kIllegal;
                        endcase
                end
        end

        assign illegal = (instrKind == kIllegal);

endmodule

`default_nettype wire

// ==== design/ctrlIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface ctrlIf
        import decodePkg::*;
();

        aluOp_t aluOp;
        logic   aluSrc;
        logic   zeroExtend;
        logic   shamtOperand;
        logic   zeroOperands;
        logic   swapOperands;
        logic   regWrite;
        logic   regDst;
        logic   hiLoMove;
        logic   hiLoAccum;
        logic   hiLoSubtract;

        modport aluSide (output aluOp, aluSrc, zeroExtend, shamtOperand, zeroOperands,
                         swapOperands);
        modport wbSide  (output regWrite, regDst, hiLoMove, hiLoAccum, hiLoSubtract);
        modport stage   (input aluOp, aluSrc, zeroExtend, shamtOperand, zeroOperands,
                         swapOperands, regWrite, regDst, hiLoMove, hiLoAccum, hiLoSubtract);

endinterface

`default_nettype wire

// ==== design/decodePkg.sv ====
`default_nettype none

package decodePkg;

        //////////////////////////////
        // Instruction fields

        typedef logic [31:0] instr_t;
        typedef logic [5:0]  opcode_t;
        typedef logic [5:0]  funct_t;
        typedef logic [4:0]  regIdx_t;          // rs, rt, rd or shift amount

        //////////////////////////////
        // Primary opcodes

        localparam opcode_t opSpecial  = 6'b000000;
        localparam opcode_t opSpecial2 = 6'b011100;
        localparam opcode_t opSpecial3 = 6'b011111;
        localparam opcode_t opAddi     = 6'b001000;
        localparam opcode_t opAddiu    = 6'b001001;
        localparam opcode_t opSlti     = 6'b001010;
        localparam opcode_t opSltiu    = 6'b001011;
        localparam opcode_t opAndi     = 6'b001100;
        localparam opcode_t opOri      = 6'b001101;
        localparam opcode_t opXori     = 6'b001110;

        //////////////////////////////
        // Function codes

        localparam funct_t fnSll   = 6'b000000; // SPECIAL group
        localparam funct_t fnSrl   = 6'b000010; // Also ROTR
        localparam funct_t fnSra   = 6'b000011;
        localparam funct_t fnSllv  = 6'b000100;
        localparam funct_t fnSrlv  = 6'b000110; // Also ROTRV
        localparam funct_t fnSrav  = 6'b000111;
        localparam funct_t fnMovz  = 6'b001010;
        localparam funct_t fnMovn  = 6'b001011;
        localparam funct_t fnMult  = 6'b011000;
        localparam funct_t fnMultu = 6'b011001;
        localparam funct_t fnAdd   = 6'b100000;
        localparam funct_t fnAddu  = 6'b100001;
        localparam funct_t fnSub   = 6'b100010;
        localparam funct_t fnAnd   = 6'b100100;
        localparam funct_t fnOr    = 6'b100101;
        localparam funct_t fnXor   = 6'b100110;
        localparam funct_t fnNor   = 6'b100111;
        localparam funct_t fnSlt   = 6'b101010;
        localparam funct_t fnSltu  = 6'b101011;
        localparam funct_t fnMadd  = 6'b000000; // SPECIAL2 group
        localparam funct_t fnMul   = 6'b000010;
        localparam funct_t fnMsub  = 6'b000100;
        localparam funct_t fnBshfl = 6'b100000; // SPECIAL3 group

        // Sub-selectors held in the rs or sa fields
        localparam regIdx_t rotrSel = 5'b00001;
        localparam regIdx_t saSeb   = 5'b10000;
        localparam regIdx_t saSeh   = 5'b11000;

        //////////////////////////////
        // Decoded kinds and ALU codes

        typedef enum logic [5:0] {
                kNop, kAdd, kAddu, kAddi, kAddiu, kSub,
                kMul, kMult, kMultu, kMadd, kMsub,
                kAnd, kAndi, kOr, kOri, kNor, kXor, kXori,
                kSll, kSrl, kSllv, kSrlv, kSra, kSrav, kRotr, kRotrv,
                kSlt, kSlti, kSltu, kSltiu, kMovn, kMovz, kSeb, kSeh,
                kIllegal
        } instrKind_t;

        typedef enum logic [3:0] {
                aluAnd  = 4'd0,  aluOr   = 4'd1,  aluAdd  = 4'd2,  aluNor  = 4'd3,
                aluXor  = 4'd4,  aluSllv = 4'd5,  aluSub  = 4'd6,  aluSlt  = 4'd7,
                aluMul  = 4'd8,  aluSeh  = 4'd9,  aluSeb  = 4'd10, aluSll  = 4'd11,
                aluSrl  = 4'd12, aluRotr = 4'd13, aluSra  = 4'd14, aluSrlv = 4'd15
        } aluOp_t;

endpackage

`default_nettype wire
